// File: ls_isa_pkg.sv
package ls_isa_pkg;

  localparam int XLEN = 32;  // Data and address width

  // Opcode, loads first then stores
  typedef enum logic [2:0] {
    OP_LB  = 3'd0,  // Signed byte load
    OP_LBU = 3'd1,  // Unsigned byte load
    OP_LH  = 3'd2,  // Signed halfword load
    OP_LHU = 3'd3,  // Unsigned halfword load
    OP_LW  = 3'd4,  // Word load
    OP_SB  = 3'd5,  // Byte store
    OP_SH  = 3'd6,  // Halfword store
    OP_SW  = 3'd7   // Word store
  } ls_op_e;

  // Access width, values follow the byte, half, word enable bit order
  typedef enum logic [1:0] {
    W_BYTE = 2'd0,
    W_HALF = 2'd1,
    W_WORD = 2'd2
  } ls_width_e;

  function automatic logic op_is_store(ls_op_e op);
    return op inside {OP_SB, OP_SH, OP_SW};
  endfunction

  function automatic ls_width_e op_width(ls_op_e op);
    case (op)
      OP_LB, OP_LBU, OP_SB: return W_BYTE;
      OP_LH, OP_LHU, OP_SH: return W_HALF;
      default:              return W_WORD;  // LW and SW
    endcase
  endfunction

  // Only sub-word loads can be signed
  function automatic logic op_is_signed(ls_op_e op);
    return (op == OP_LB) || (op == OP_LH);
  endfunction

endpackage

// File: ls_bus_pkg.sv
package ls_bus_pkg;

  // Stage 1 to stage 2, one memory access
  typedef struct packed {
    logic                        valid;      // Access present this cycle
    logic                        write;      // Store when set, load otherwise
    ls_isa_pkg::ls_width_e       width;      // Byte, half or word
    logic                        is_signed;  // Load wants sign extension
    logic [ls_isa_pkg::XLEN-1:0] addr;       // Effective byte address
    logic [ls_isa_pkg::XLEN-1:0] wdata;      // Store data, right-justified
  } mem_req_t;

  // Stage 2 to stage 3, load data only
  typedef struct packed {
    logic                        valid;      // Raised for loads only
    ls_isa_pkg::ls_width_e       width;      // Carried along for extension
    logic                        is_signed;
    logic [ls_isa_pkg::XLEN-1:0] rdata;      // Right-justified, zero-filled
  } mem_rsp_t;

  // Response view of a request, data left for the memory to fill
  function automatic mem_rsp_t rsp_from_req(mem_req_t req);
    mem_rsp_t rsp;
    rsp.valid     = req.valid && !req.write;
    rsp.width     = req.width;
    rsp.is_signed = req.is_signed;
    rsp.rdata     = '0;
    return rsp;
  endfunction

  // Number of bytes touched by an access
  function automatic int unsigned width_bytes(ls_isa_pkg::ls_width_e w);
    case (w)
      ls_isa_pkg::W_BYTE: return 1;
      ls_isa_pkg::W_HALF: return 2;
      default:            return 4;
    endcase
  endfunction

endpackage

// File: ls_agen.sv
module ls_agen (
  input  logic                        i_clock,
  input  logic                        i_rst_n,
  input  logic                        i_valid,       // One-cycle strobe per op
  input  ls_isa_pkg::ls_op_e          i_op,
  input  logic [ls_isa_pkg::XLEN-1:0] i_base,
  input  logic [ls_isa_pkg::XLEN-1:0] i_offset,
  input  logic [ls_isa_pkg::XLEN-1:0] i_store_data,
  output ls_bus_pkg::mem_req_t        o_req          // Registered request
);

  // Decoded view of the incoming op
  logic                        dec_write;
  ls_isa_pkg::ls_width_e       dec_width;
  logic                        dec_signed;
  logic [ls_isa_pkg::XLEN-1:0] eff_addr;

  // Registered request fields
  logic                        valid_q;
  logic                        write_q;
  ls_isa_pkg::ls_width_e       width_q;
  logic                        signed_q;
  logic [ls_isa_pkg::XLEN-1:0] addr_q;
  logic [ls_isa_pkg::XLEN-1:0] wdata_q;

  // Base plus offset, carry out dropped
  assign eff_addr = i_base + i_offset;

  // Opcode decode
  assign dec_write  = ls_isa_pkg::op_is_store(i_op);
  assign dec_width  = ls_isa_pkg::op_width(i_op);
  assign dec_signed = ls_isa_pkg::op_is_signed(i_op);

  // Strobe pipe, the only state reset touches here
  always_ff @(posedge i_clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_valid;
    end
  end

  // Payload only moves with a strobe
  always_ff @(posedge i_clock) begin
    if (i_valid) begin
      write_q  <= dec_write;
      width_q  <= dec_width;
      signed_q <= dec_signed;
      addr_q   <= eff_addr;
      // Loads carry no data
      wdata_q  <= dec_write ? i_store_data : '0;
    end
  end

  assign o_req = '{
    valid:     valid_q,
    write:     write_q,
    width:     width_q,
    is_signed: signed_q,
    addr:      addr_q,
    wdata:     wdata_q
  };

endmodule

// File: data_memory.sv
module data_memory #(
  parameter int NB_ADDR = 7  // Byte address bits, 4 to 16
) (
  input  logic                 i_clock,
  input  logic                 i_rst_n,
  input  ls_bus_pkg::mem_req_t i_req,   // From address generation
  output ls_bus_pkg::mem_rsp_t o_rsp    // To load extension
);

  localparam int DEPTH = 1 << NB_ADDR;  // Bytes in the array

  logic [7:0] mem [DEPTH];

  // Byte addresses of the access, wrap modulo depth
  logic [NB_ADDR-1:0] byte_addr [4];

  logic                        do_write;
  logic                        do_read;
  logic [ls_isa_pkg::XLEN-1:0] rd_word;   // Assembled read data
  ls_bus_pkg::mem_rsp_t        rsp_next;  // Response before the data goes in

  logic                        rsp_valid_q;
  ls_isa_pkg::ls_width_e       rsp_width_q;
  logic                        rsp_signed_q;
  logic [ls_isa_pkg::XLEN-1:0] rsp_rdata_q;

  // Array starts cleared
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 8'h00;
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      byte_addr[i] = i_req.addr[NB_ADDR-1:0] + NB_ADDR'(i);  // Carry drops, wraps
    end
  end

  assign do_write = i_req.valid && i_req.write;
  assign do_read  = i_req.valid && !i_req.write;
  assign rsp_next = ls_bus_pkg::rsp_from_req(i_req);

  // Big-endian write, MSB of the access at the lowest address
  always_ff @(posedge i_clock) begin
    if (do_write) begin
      case (i_req.width)
        ls_isa_pkg::W_BYTE: begin
          mem[byte_addr[0]] <= i_req.wdata[7:0];
        end
        ls_isa_pkg::W_HALF: begin
          mem[byte_addr[0]] <= i_req.wdata[15:8];
          mem[byte_addr[1]] <= i_req.wdata[7:0];
        end
        ls_isa_pkg::W_WORD: begin
          mem[byte_addr[0]] <= i_req.wdata[31:24];
          mem[byte_addr[1]] <= i_req.wdata[23:16];
          mem[byte_addr[2]] <= i_req.wdata[15:8];
          mem[byte_addr[3]] <= i_req.wdata[7:0];
        end
        default: ;  // Unused encoding, no write
      endcase
    end
  end

  // Same byte order on read, right-justified with zeros above
  always_comb begin
    rd_word = '0;
    for (int i = 0; i < 4; i++) begin
      if (i < int'(ls_bus_pkg::width_bytes(i_req.width))) begin
        rd_word[8*(int'(ls_bus_pkg::width_bytes(i_req.width)) - 1 - i) +: 8] =
          mem[byte_addr[i]];
      end
    end
  end

  // Response strobe, loads only
  always_ff @(posedge i_clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rsp_next.valid;
    end
  end

  // Read port, one cycle latency
  always_ff @(posedge i_clock) begin
    if (do_read) begin
      rsp_width_q  <= rsp_next.width;
      rsp_signed_q <= rsp_next.is_signed;
      rsp_rdata_q  <= rd_word;
    end
  end

  assign o_rsp = '{
    valid:     rsp_valid_q,
    width:     rsp_width_q,
    is_signed: rsp_signed_q,
    rdata:     rsp_rdata_q
  };

endmodule

// File: ls_load_extend.sv
module ls_load_extend (
  input  logic                        i_clock,
  input  logic                        i_rst_n,
  input  ls_bus_pkg::mem_rsp_t        i_rsp,         // Zero-filled load data
  output logic                        o_load_valid,  // Registered result strobe
  output logic [ls_isa_pkg::XLEN-1:0] o_load_data    // Registered load result
);

  logic [ls_isa_pkg::XLEN-1:0] ext_data;  // Extended, not yet registered

  // Sign bit replicated upward for signed sub-word loads
  always_comb begin
    ext_data = i_rsp.rdata;  // Unsigned and word pass through
    if (i_rsp.is_signed) begin
      case (i_rsp.width)
        ls_isa_pkg::W_BYTE: begin
          ext_data = {{(ls_isa_pkg::XLEN-8){i_rsp.rdata[7]}}, i_rsp.rdata[7:0]};
        end
        ls_isa_pkg::W_HALF: begin
          ext_data = {{(ls_isa_pkg::XLEN-16){i_rsp.rdata[15]}}, i_rsp.rdata[15:0]};
        end
        default: begin
          ext_data = i_rsp.rdata;  // Word is already full width
        end
      endcase
    end
  end

  // Result strobe
  always_ff @(posedge i_clock or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_load_valid <= 1'b0;
    end else begin
      o_load_valid <= i_rsp.valid;
    end
  end

  // Result data, held between loads
  always_ff @(posedge i_clock) begin
    if (i_rsp.valid) begin
      o_load_data <= ext_data;
    end
  end

endmodule

// File: ls_unit.sv
module ls_unit #(
  parameter int NB_ADDR = 7  // Memory address bits, depth is 2**NB_ADDR bytes
) (
  input  logic                        i_clock,
  input  logic                        i_rst_n,
  input  logic                        i_valid,       // One op per strobe
  input  ls_isa_pkg::ls_op_e          i_op,
  input  logic [ls_isa_pkg::XLEN-1:0] i_base,
  input  logic [ls_isa_pkg::XLEN-1:0] i_offset,
  input  logic [ls_isa_pkg::XLEN-1:0] i_store_data,
  output logic                        o_load_valid,  // Three edges after the strobe
  output logic [ls_isa_pkg::XLEN-1:0] o_load_data
);

  ls_bus_pkg::mem_req_t req;  // Stage 1 to 2
  ls_bus_pkg::mem_rsp_t rsp;  // Stage 2 to 3

  // Address generation and decode
  ls_agen u_agen (
    .i_clock      (i_clock),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_op         (i_op),
    .i_base       (i_base),
    .i_offset     (i_offset),
    .i_store_data (i_store_data),
    .o_req        (req)
  );

  // Byte array, big-endian
  data_memory #(
    .NB_ADDR (NB_ADDR)
  ) u_data_memory (
    .i_clock (i_clock),
    .i_rst_n (i_rst_n),
    .i_req   (req),
    .o_rsp   (rsp)
  );

  // Sign or zero extension
  ls_load_extend u_load_extend (
    .i_clock      (i_clock),
    .i_rst_n      (i_rst_n),
    .i_rsp        (rsp),
    .o_load_valid (o_load_valid),
    .o_load_data  (o_load_data)
  );

endmodule

// File: tb_ls_unit.sv
module tb_ls_unit;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 40;
  localparam int NB_ADDR     = 7;
  localparam int MEM_BYTES   = 1 << NB_ADDR;
  localparam int DRAIN_LIMIT = 20;  // Cycles allowed for results still in flight
  // Strobe taken one period after the drive, result at k+2, sampled half a period later
  localparam int LATENCY_NS  = 3 * CLK_PERIOD + CLK_PERIOD / 2;

  // One outstanding load
  typedef struct packed {
    logic [31:0] data;     // Expected extended result
    logic [63:0] t_issue;  // Time the strobe was driven
  } expect_t;

  logic                        i_clock;
  logic                        i_rst_n;
  logic                        i_valid;
  ls_isa_pkg::ls_op_e          i_op;
  logic [31:0]                 i_base;
  logic [31:0]                 i_offset;
  logic [31:0]                 i_store_data;
  logic                        o_load_valid;
  logic [31:0]                 o_load_data;

  logic [7:0] model_mem [MEM_BYTES];  // Mirror of the DUT byte array
  expect_t    exp_q [$];              // Loads in issue order
  string      name_q [$];             // Test name per load
  int         seed = 23;

  ls_unit #(
    .NB_ADDR (NB_ADDR)
  ) DUT (
    .i_clock      (i_clock),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_op         (i_op),
    .i_base       (i_base),
    .i_offset     (i_offset),
    .i_store_data (i_store_data),
    .o_load_valid (o_load_valid),
    .o_load_data  (o_load_data)
  );

  initial begin
    i_clock = 1'b0;
    forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  // Bytes touched by an opcode
  function automatic int op_bytes(ls_isa_pkg::ls_op_e op);
    case (op)
      ls_isa_pkg::OP_LB, ls_isa_pkg::OP_LBU, ls_isa_pkg::OP_SB: return 1;
      ls_isa_pkg::OP_LH, ls_isa_pkg::OP_LHU, ls_isa_pkg::OP_SH: return 2;
      default:                                                  return 4;
    endcase
  endfunction

  // Big-endian store into the model, first byte is the MSB of the access
  task automatic store_model(input ls_isa_pkg::ls_op_e op, input logic [31:0] addr,
                             input logic [31:0] data);
    int                 nbytes;
    logic [NB_ADDR-1:0] idx;
    nbytes = op_bytes(op);
    for (int i = 0; i < nbytes; i++) begin
      idx = addr[NB_ADDR-1:0] + NB_ADDR'(i);  // Wraps past the top
      model_mem[idx] = data[8*(nbytes-1-i) +: 8];
    end
  endtask

  // Expected load result from the model, extended to 32 bits
  function automatic logic [31:0] expect_load(ls_isa_pkg::ls_op_e op, logic [31:0] addr);
    logic [31:0]        raw;
    logic [NB_ADDR-1:0] idx;
    int                 nbytes;
    raw    = '0;
    nbytes = op_bytes(op);
    for (int i = 0; i < nbytes; i++) begin
      idx = addr[NB_ADDR-1:0] + NB_ADDR'(i);
      raw = {raw[23:0], model_mem[idx]};  // Lowest address ends up on top
    end
    case (op)
      ls_isa_pkg::OP_LB: return {{24{raw[7]}}, raw[7:0]};
      ls_isa_pkg::OP_LH: return {{16{raw[15]}}, raw[15:0]};
      default:           return raw;  // Zero-filled already
    endcase
  endfunction

  // One op per call, strobe stays high for back-to-back calls
  task automatic issue(input ls_isa_pkg::ls_op_e op, input logic [31:0] base,
                       input logic [31:0] offset, input logic [31:0] data,
                       input string name);
    logic [31:0] addr;
    expect_t     e;
    @(posedge i_clock);
    i_valid      <= 1'b1;
    i_op         <= op;
    i_base       <= base;
    i_offset     <= offset;
    i_store_data <= data;
    addr = base + offset;
    if (op inside {ls_isa_pkg::OP_SB, ls_isa_pkg::OP_SH, ls_isa_pkg::OP_SW}) begin
      store_model(op, addr, data);
    end else begin
      e.data    = expect_load(op, addr);
      e.t_issue = $time;
      exp_q.push_back(e);
      name_q.push_back(name);
    end
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge i_clock);
      i_valid <= 1'b0;
    end
  endtask

  // Compare on the falling edge, outputs settled since the rising one
  always @(negedge i_clock) begin : compare
    expect_t e;
    string   nm;
    if (i_rst_n && o_load_valid) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected load result 0x%08h with no load outstanding", o_load_data);
        $display(">>> FAIL");
        $fatal(1, "Unexpected load result");
      end else begin
        e  = exp_q.pop_front();
        nm = name_q.pop_front();
        check({nm, "_latency"}, 32'(LATENCY_NS), 32'($time - e.t_issue));
        check(nm, e.data, o_load_data);
      end
    end
  end

  initial begin : stimulus
    ls_isa_pkg::ls_op_e op;
    logic [31:0]        r;
    logic [31:0]        addr;
    logic [31:0]        base;
    logic [31:0]        offs;
    logic [31:0]        wdat;
    int                 wait_cnt;
    for (int i = 0; i < MEM_BYTES; i++) begin
      model_mem[i] = 8'h00;  // DUT array starts cleared too
    end
    i_rst_n      = 1'b0;
    i_valid      = 1'b0;
    i_op         = ls_isa_pkg::OP_LW;
    i_base       = '0;
    i_offset     = '0;
    i_store_data = '0;
    repeat (8) @(posedge i_clock);
    i_rst_n <= 1'b1;

    // Quiet output after reset, sampled mid-cycle
    for (int n = 0; n < 10; n++) begin
      @(negedge i_clock);
      check("reset_idle", 32'd0, 32'(o_load_valid));
    end

    // Word round trip, upper base bits fall outside the array
    for (int n = 0; n < 6; n++) begin
      addr = 32'(8 * n + 4);
      wdat = $random(seed);
      issue(ls_isa_pkg::OP_SW, 32'h1000 + addr, 32'h0, wdat, "word_store");
      issue(ls_isa_pkg::OP_LW, 32'h2000, addr, '0, "word_round_trip");
      issue(ls_isa_pkg::OP_LBU, addr - 32'd4, 32'd4, '0, "word_msb_byte");
      idle_cycles(1);
    end

    // Every byte has its top bit set
    issue(ls_isa_pkg::OP_SW, 32'h40, 32'h0, 32'h8CF0_A59E, "ext_store");
    for (int n = 0; n < 4; n++) begin
      issue(ls_isa_pkg::OP_LB, 32'h40, 32'(n), '0, "ext_lb");
      issue(ls_isa_pkg::OP_LBU, 32'h40, 32'(n), '0, "ext_lbu");
    end
    issue(ls_isa_pkg::OP_LH, 32'h40, 32'h0, '0, "ext_lh_low_addr");
    issue(ls_isa_pkg::OP_LHU, 32'h40, 32'h0, '0, "ext_lhu_low_addr");
    issue(ls_isa_pkg::OP_LH, 32'h42, 32'h0, '0, "ext_lh_high_addr");
    issue(ls_isa_pkg::OP_LHU, 32'h42, 32'h0, '0, "ext_lhu_high_addr");
    idle_cycles(2);

    // Partial stores inside one word
    issue(ls_isa_pkg::OP_SW, 32'h50, 32'h0, 32'h1122_3344, "partial_base");
    issue(ls_isa_pkg::OP_SB, 32'h50, 32'h1, 32'h0000_00AA, "partial_sb");
    issue(ls_isa_pkg::OP_LW, 32'h50, 32'h0, '0, "partial_after_sb");
    issue(ls_isa_pkg::OP_SH, 32'h52, 32'h0, 32'h0000_BEEF, "partial_sh");
    issue(ls_isa_pkg::OP_LW, 32'h50, 32'h0, '0, "partial_after_sh");
    idle_cycles(2);

    // One load per cycle, then store followed at once by a load
    for (int n = 0; n < 8; n++) begin
      issue(ls_isa_pkg::OP_LW, 32'h0, 32'(4 * n), '0, "b2b_load");
    end
    issue(ls_isa_pkg::OP_SW, 32'h60, 32'h0, 32'hDEAD_BEEF, "b2b_store");
    issue(ls_isa_pkg::OP_LW, 32'h60, 32'h0, '0, "b2b_load_after_sw");
    issue(ls_isa_pkg::OP_SH, 32'h62, 32'h0, 32'h0000_1234, "b2b_store_half");
    issue(ls_isa_pkg::OP_LHU, 32'h62, 32'h0, '0, "b2b_load_after_sh");
    issue(ls_isa_pkg::OP_LW, 32'h60, 32'h0, '0, "b2b_word_after_sh");
    idle_cycles(4);

    // Word across the top, lands in bytes 0 and 1
    issue(ls_isa_pkg::OP_SW, 32'(MEM_BYTES - 2), 32'h0, 32'hCAFE_F00D, "wrap_store");
    issue(ls_isa_pkg::OP_LW, 32'(MEM_BYTES - 2), 32'h0, '0, "wrap_load");
    issue(ls_isa_pkg::OP_LBU, 32'h0, 32'h0, '0, "wrap_byte0");
    issue(ls_isa_pkg::OP_LBU, 32'h0, 32'h1, '0, "wrap_byte1");
    idle_cycles(1);

    for (int n = 0; n < 400; n++) begin
      r = $random(seed);
      if (n % 10 == 0) begin
        op   = r[0] ? ls_isa_pkg::OP_SW : ls_isa_pkg::OP_LW;  // Top of memory
        base = 32'(MEM_BYTES - 1 - (n / 10) % 3);
        offs = '0;
      end else begin
        op   = ls_isa_pkg::ls_op_e'(r[2:0]);
        base = $random(seed);
        offs = $random(seed);
      end
      wdat = $random(seed);
      issue(op, base, offs, wdat, $sformatf("random_%0d", n));
      if (r[5:4] == 2'b00) begin
        idle_cycles(1);  // Occasional gap
      end
    end
    idle_cycles(1);

    // Drain, bounded
    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
      @(posedge i_clock);
      wait_cnt++;
    end
    if (exp_q.size() == 0) begin
      idle_cycles(4);  // Any stray result trips the compare process
    end
    if (exp_q.size() != 0) begin
      $display("Timed out after %0d cycles with %0d load results missing",
               DRAIN_LIMIT, exp_q.size());
      $display(">>> FAIL");
      $fatal(1, "Load results never arrived");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// File: ls_unit.f
ls_isa_pkg.sv
ls_bus_pkg.sv
ls_agen.sv
data_memory.sv
ls_load_extend.sv
ls_unit.sv
tb_ls_unit.sv

// File: Makefile
# Verilator build and run for the load/store unit testbench
# Any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_ls_unit
FILELIST  ?= ls_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j $(JOBS)

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard *.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation, search $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables:"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR) LOG=$(LOG) JOBS=$(JOBS)"
	@echo "  VFLAGS=$(VFLAGS)"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the simulator status alone does not
test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx -- '>>> PASS' $(LOG); then \
		echo "Simulation passed, see $(LOG)"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
